// File: project.f
rcu_cfg_pkg.sv
rcu_op_pkg.sv
free_list.sv
rename_table.sv
phys_regfile.sv
reorder_buffer.sv
rcu.sv
tb_clock.sv
rcu_tb.sv

// File: Bender.yml
package:
  name: rcu

sources:
  - files:
      - rcu_cfg_pkg.sv
      - rcu_op_pkg.sv
      - free_list.sv
      - rename_table.sv
      - phys_regfile.sv
      - reorder_buffer.sv
      - rcu.sv
  - target: test
    files:
      - tb_clock.sv
      - rcu_tb.sv

// File: rcu_tb.sv
// register control unit testbench
`timescale 1ns/1ps

module rcu_tb
    import rcu_cfg_pkg::*;
    import rcu_op_pkg::*;
();

    localparam int wait_limit = 200;

    typedef struct {
        logic [pc_width-1:0]   pc;
        op_kind_t              kind;
        rob_line_t             line;
        areg_t                 rd;
        preg_t                 prd;
        preg_t                 old;
        preg_t                 ps1;
        preg_t                 ps2;
        logic [data_width-1:0] exp1;
        logic [data_width-1:0] exp2;
        bit                    done;
    } entry_t;

    logic                  clk;
    logic                  reset;
    logic                  trap;
    logic                  dispatch_valid;
    op_kind_t              dispatch_kind;
    logic [pc_width-1:0]   dispatch_pc;
    areg_t                 dispatch_rs1;
    areg_t                 dispatch_rs2;
    areg_t                 dispatch_rd;
    logic                  dispatch_uses_rd;
    logic                  dispatch_ready;
    logic                  issue_valid;
    op_kind_t              issue_kind;
    rob_line_t             issue_rob_line;
    preg_t                 issue_prd;
    logic [data_width-1:0] issue_rs1_data;
    logic [data_width-1:0] issue_rs2_data;
    logic                  fu_ready;
    logic                  wb_valid;
    rob_line_t             wb_rob_line;
    logic [data_width-1:0] wb_data;
    logic                  commit_valid;
    logic [pc_width-1:0]   commit_pc;
    areg_t                 commit_rd;
    preg_t                 commit_prd;

    // reference model state
    entry_t              inflight [$];
    int                  n_issued;
    preg_t               spec_map [arch_regs];
    preg_t               cm_map [arch_regs];
    preg_t               free_q [$];
    int                  free_rd;
    int                  free_cm_rd;
    logic [pc_width-1:0] preg_pc [phys_regs];
    bit                  preg_written [phys_regs];
    rob_line_t           tail_line;
    logic [pc_width-1:0] next_pc;
    int                  cyc;

    // function unit model, one pending write-back per issue
    rob_line_t           wb_line_q [$];
    logic [pc_width-1:0] wb_pc_q [$];
    int                  wb_due_q [$];

    // 0 idle, 1 random, 2 every cycle
    int          dispatch_mode;
    bit          fu_hold;
    bit          trap_req;
    logic [31:0] lfsr;
    int          waited;

    tb_clock #(.period_ns(100)) u_clock (.clk(clk));

    rcu uut (.*);

    // taps 32 22 2 1
    function automatic bit lfsr_step();
        bit fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // value the function unit returns for the instruction at pc
    function automatic logic [data_width-1:0] data_of(input logic [pc_width-1:0] pc);
        return {pc ^ 32'h3c6e_f372, ~pc + 32'd7};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    // called right after a falling edge
    task automatic drive_inputs();
        logic [1:0] k;
        k = 2'(rand_bits(2));
        dispatch_kind    = (k == 2'd3) ? op_store : (k == 2'd2) ? op_load : op_alu;
        dispatch_uses_rd = (dispatch_kind != op_store);
        // few registers so that dependencies are common
        dispatch_rs1     = areg_t'(rand_bits(3));
        dispatch_rs2     = areg_t'(rand_bits(3));
        dispatch_rd      = areg_t'(rand_bits(3));
        dispatch_pc      = next_pc;
        dispatch_valid   = (dispatch_mode == 2) || (dispatch_mode == 1 && rand_bits(2) != 0);
        fu_ready         = !fu_hold && rand_bits(2) != 0;
        wb_valid         = 1'b0;
        trap             = trap_req;
        if (trap_req) begin
            // squashed lines never write back
            dispatch_valid = 1'b0;
            fu_ready       = 1'b0;
            trap_req       = 1'b0;
            wb_line_q.delete();
            wb_pc_q.delete();
            wb_due_q.delete();
        end else if (wb_due_q.size() > 0 && wb_due_q[0] <= cyc) begin
            wb_valid    = 1'b1;
            wb_rob_line = wb_line_q.pop_front();
            wb_data     = data_of(wb_pc_q.pop_front());
            void'(wb_due_q.pop_front());
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            drive_inputs();
        end
    endtask

    task automatic drain();
        dispatch_mode = 0;
        fu_hold       = 0;
        waited        = 0;
        while (inflight.size() > 0 && waited < wait_limit) begin
            @(negedge clk);
            drive_inputs();
            waited++;
        end
        assert (inflight.size() == 0) else abort_run("timeout: the buffer did not drain");
    endtask

    // compare process, sees the values just before each rising edge
    always @(posedge clk) begin
        entry_t e;
        bit     needs;
        if (!reset) begin
            cyc++;
            assert (dispatch_ready == (inflight.size() < rob_depth && free_rd < free_q.size()))
                else report_mismatch("dispatch_ready disagrees with buffer and free list");
            if (issue_valid && fu_ready) begin
                assert (n_issued < inflight.size())
                    else report_mismatch("issue with no waiting entry");
                e = inflight[n_issued];
                assert (issue_rob_line == e.line && issue_kind == e.kind && issue_prd == e.prd)
                    else report_mismatch($sformatf("issue line %0d prd %0d, expected %0d %0d",
                        issue_rob_line, issue_prd, e.line, e.prd));
                assert (issue_rs1_data == e.exp1 && issue_rs2_data == e.exp2)
                    else report_mismatch($sformatf("operands %h %h, expected %h %h",
                        issue_rs1_data, issue_rs2_data, e.exp1, e.exp2));
                assert (preg_written[e.ps1] && preg_written[e.ps2])
                    else report_mismatch("issue before a source was written back");
                assert (e.kind != op_store || n_issued == 0)
                    else report_mismatch("store issued ahead of an older entry");
                n_issued++;
                wb_line_q.push_back(e.line);
                wb_pc_q.push_back(e.pc);
                wb_due_q.push_back(cyc + int'(rand_bits(2)));
            end
            if (commit_valid) begin
                assert (inflight.size() > 0 && n_issued > 0)
                    else report_mismatch("commit with no issued entry");
                e = inflight.pop_front();
                n_issued--;
                assert (commit_pc == e.pc && commit_rd == e.rd && commit_prd == e.prd)
                    else report_mismatch($sformatf("commit pc %h rd %0d prd %0d, expected %h %0d %0d",
                        commit_pc, commit_rd, commit_prd, e.pc, e.rd, e.prd));
                assert (e.done) else report_mismatch("commit before write-back");
                if (e.prd != '0) begin
                    cm_map[e.rd] = e.prd;
                    free_cm_rd++;
                end
                if (e.old != '0) begin
                    free_q.push_back(e.old);
                end
            end
            if (wb_valid) begin
                foreach (inflight[i]) begin
                    if (inflight[i].line == wb_rob_line) begin
                        inflight[i].done = 1'b1;
                        preg_written[inflight[i].prd] = 1'b1;
                    end
                end
            end
            if (trap) begin
                inflight.delete();
                n_issued = 0;
                spec_map = cm_map;
                free_rd  = free_cm_rd;
            end else if (dispatch_valid && dispatch_ready) begin
                needs  = dispatch_uses_rd && dispatch_rd != '0;
                e.pc   = dispatch_pc;
                e.kind = dispatch_kind;
                e.line = tail_line;
                e.ps1  = spec_map[dispatch_rs1];
                e.ps2  = spec_map[dispatch_rs2];
                e.exp1 = (e.ps1 == '0) ? '0 : data_of(preg_pc[e.ps1]);
                e.exp2 = (e.ps2 == '0) ? '0 : data_of(preg_pc[e.ps2]);
                e.done = 1'b0;
                e.rd   = needs ? dispatch_rd : '0;
                e.prd  = '0;
                e.old  = '0;
                if (needs) begin
                    e.prd = free_q[free_rd];
                    free_rd++;
                    e.old = spec_map[dispatch_rd];
                    spec_map[dispatch_rd] = e.prd;
                    preg_pc[e.prd] = dispatch_pc;
                    preg_written[e.prd] = 1'b0;
                end
                inflight.push_back(e);
                tail_line++;
                next_pc += 32'd4;
            end
        end
    end

    initial begin
        lfsr = 32'h5bdca779;
        reset = 1'b1;
        trap = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_kind = op_alu;
        dispatch_pc = '0;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        dispatch_rd = '0;
        dispatch_uses_rd = 1'b0;
        fu_ready = 1'b0;
        wb_valid = 1'b0;
        wb_rob_line = '0;
        wb_data = '0;
        for (int i = 0; i < arch_regs; i++) begin
            spec_map[i] = '0;
            cm_map[i] = '0;
        end
        for (int i = 0; i < phys_regs; i++) begin
            preg_pc[i] = '0;
            preg_written[i] = 1'b1;
        end
        // free list starts as P1..P31
        for (int i = 1; i < phys_regs; i++) begin
            free_q.push_back(preg_t'(i));
        end
        free_rd = 0;
        free_cm_rd = 0;
        n_issued = 0;
        tail_line = '0;
        next_pc = 32'h0000_1000;
        cyc = 0;
        dispatch_mode = 0;
        fu_hold = 1'b0;
        trap_req = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (dispatch_ready && !issue_valid && !commit_valid)
            else report_mismatch("outputs after reset are not idle");

        // fill the buffer while the function unit stalls
        dispatch_mode = 2;
        fu_hold = 1'b1;
        waited = 0;
        while (inflight.size() < rob_depth && waited < wait_limit) begin
            @(negedge clk);
            if (inflight.size() > 0) begin
                assert (issue_valid && issue_rob_line == inflight[0].line
                        && issue_prd == inflight[0].prd)
                    else report_mismatch("held issue entry changed");
            end
            drive_inputs();
            waited++;
        end
        assert (inflight.size() == rob_depth) else abort_run("timeout: the buffer did not fill");
        assert (!dispatch_ready) else report_mismatch("dispatch_ready high with a full buffer");
        dispatch_mode = 0;
        fu_hold = 1'b0;
        waited = 0;
        while (!dispatch_ready && waited < wait_limit) begin
            @(negedge clk);
            drive_inputs();
            waited++;
        end
        assert (dispatch_ready) else abort_run("timeout: dispatch_ready stayed low");

        // random traffic
        dispatch_mode = 1;
        run_cycles(400);
        drain();

        // flush with entries in flight, some issued and some waiting
        dispatch_mode = 1;
        run_cycles(10);
        dispatch_mode = 2;
        fu_hold = 1'b1;
        waited = 0;
        while (inflight.size() < 4 && waited < wait_limit) begin
            @(negedge clk);
            drive_inputs();
            waited++;
        end
        assert (inflight.size() >= 4) else abort_run("timeout: no entries in flight for the trap");
        trap_req = 1'b1;
        run_cycles(1);
        // one idle cycle with trap low, so a surviving entry would show up
        dispatch_mode = 0;
        run_cycles(1);
        @(negedge clk);
        assert (dispatch_ready && !issue_valid && !commit_valid)
            else report_mismatch("buffer not empty after trap");
        fu_hold = 1'b0;
        dispatch_mode = 1;
        drive_inputs();
        run_cycles(200);
        drain();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tb_clock.sv
// testbench clock source
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

// File: rcu.sv
// register control unit top
`timescale 1ns/1ps

module rcu import rcu_cfg_pkg::*, rcu_op_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  trap,
    input  logic                  dispatch_valid,
    input  op_kind_t              dispatch_kind,
    input  logic [pc_width-1:0]   dispatch_pc,
    input  areg_t                 dispatch_rs1,
    input  areg_t                 dispatch_rs2,
    input  areg_t                 dispatch_rd,
    input  logic                  dispatch_uses_rd,
    output logic                  dispatch_ready,
    output logic                  issue_valid,
    output op_kind_t              issue_kind,
    output rob_line_t             issue_rob_line,
    output preg_t                 issue_prd,
    output logic [data_width-1:0] issue_rs1_data,
    output logic [data_width-1:0] issue_rs2_data,
    input  logic                  fu_ready,
    input  logic                  wb_valid,
    input  rob_line_t             wb_rob_line,
    input  logic [data_width-1:0] wb_data,
    output logic                  commit_valid,
    output logic [pc_width-1:0]   commit_pc,
    output areg_t                 commit_rd,
    output preg_t                 commit_prd
);

    logic  alloc;
    logic  free_empty;
    logic  free_en;
    logic  commit_alloc;
    logic  src_ready1;
    logic  src_ready2;
    preg_t alloc_preg;
    preg_t free_preg;
    preg_t src1_preg;
    preg_t src2_preg;
    preg_t old_preg;
    preg_t wb_preg;
    preg_t issue_prs1;
    preg_t issue_prs2;

    free_list u_free_list (
        .clk(clk), .reset(reset), .trap(trap),
        .alloc(alloc), .free_en(free_en), .free_preg(free_preg),
        .commit_alloc(commit_alloc), .alloc_preg(alloc_preg), .empty(free_empty)
    );

    rename_table u_rename_table (
        .clk(clk), .reset(reset), .trap(trap), .rename_en(alloc),
        .rs1(dispatch_rs1), .rs2(dispatch_rs2), .rd(dispatch_rd), .new_preg(alloc_preg),
        .commit_en(commit_valid), .commit_rd(commit_rd), .commit_preg(commit_prd),
        .src1_preg(src1_preg), .src2_preg(src2_preg), .old_preg(old_preg)
    );

    reorder_buffer u_reorder_buffer (
        .clk(clk), .reset(reset), .trap(trap),
        .dispatch_valid(dispatch_valid), .dispatch_kind(dispatch_kind),
        .dispatch_pc(dispatch_pc), .dispatch_rd(dispatch_rd),
        .dispatch_uses_rd(dispatch_uses_rd), .src1_preg(src1_preg), .src2_preg(src2_preg),
        .old_preg(old_preg), .alloc_preg(alloc_preg), .free_empty(free_empty),
        .src_ready1(src_ready1), .src_ready2(src_ready2), .fu_ready(fu_ready),
        .wb_valid(wb_valid), .wb_rob_line(wb_rob_line), .dispatch_ready(dispatch_ready),
        .alloc(alloc), .commit_alloc(commit_alloc), .free_en(free_en),
        .free_preg(free_preg), .wb_preg(wb_preg), .issue_prs1(issue_prs1),
        .issue_prs2(issue_prs2), .issue_valid(issue_valid), .issue_kind(issue_kind),
        .issue_rob_line(issue_rob_line), .issue_prd(issue_prd),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
        .commit_prd(commit_prd)
    );

    phys_regfile u_phys_regfile (
        .clk(clk), .reset(reset), .rs1_preg(issue_prs1), .rs2_preg(issue_prs2),
        .wb_en(wb_valid), .wb_preg(wb_preg), .wb_data(wb_data),
        .alloc_en(alloc), .alloc_preg(alloc_preg),
        .rs1_data(issue_rs1_data), .rs2_data(issue_rs2_data),
        .rs1_ready(src_ready1), .rs2_ready(src_ready2)
    );

endmodule

// File: reorder_buffer.sv
// reorder buffer with in-order issue and commit
`timescale 1ns/1ps

module reorder_buffer import rcu_cfg_pkg::*, rcu_op_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                trap,
    input  logic                dispatch_valid,
    input  op_kind_t            dispatch_kind,
    input  logic [pc_width-1:0] dispatch_pc,
    input  areg_t               dispatch_rd,
    input  logic                dispatch_uses_rd,
    input  preg_t               src1_preg,
    input  preg_t               src2_preg,
    input  preg_t               old_preg,
    input  preg_t               alloc_preg,
    input  logic                free_empty,
    input  logic                src_ready1,
    input  logic                src_ready2,
    input  logic                fu_ready,
    input  logic                wb_valid,
    input  rob_line_t           wb_rob_line,
    output logic                dispatch_ready,
    output logic                alloc,
    output logic                commit_alloc,
    output logic                free_en,
    output preg_t               free_preg,
    output preg_t               wb_preg,
    output preg_t               issue_prs1,
    output preg_t               issue_prs2,
    output logic                issue_valid,
    output op_kind_t            issue_kind,
    output rob_line_t           issue_rob_line,
    output preg_t               issue_prd,
    output logic                commit_valid,
    output logic [pc_width-1:0] commit_pc,
    output areg_t               commit_rd,
    output preg_t               commit_prd
);

    // entry payload
    op_kind_t            kind_q  [rob_depth];
    logic [pc_width-1:0] pc_q    [rob_depth];
    areg_t               rd_q    [rob_depth];
    preg_t               prs1_q  [rob_depth];
    preg_t               prs2_q  [rob_depth];
    preg_t               prd_q   [rob_depth];
    preg_t               old_q   [rob_depth];

    logic [rob_depth-1:0] used_q;
    logic [rob_depth-1:0] issued_q;
    logic [rob_depth-1:0] finished_q;
    rob_line_t            tail_ptr;
    rob_line_t            iss_ptr;
    rob_line_t            cm_ptr;

    logic dispatch_fire;
    logic needs_preg;
    logic issue_fire;
    logic iss_store;

    assign dispatch_ready = !used_q[tail_ptr] && !free_empty;
    assign dispatch_fire  = dispatch_valid && dispatch_ready && !trap;
    assign needs_preg     = dispatch_uses_rd && (dispatch_rd != '0);
    assign alloc          = dispatch_fire && needs_preg;

    // head of the issue queue
    assign issue_prs1     = prs1_q[iss_ptr];
    assign issue_prs2     = prs2_q[iss_ptr];
    assign issue_kind     = kind_q[iss_ptr];
    assign issue_prd      = prd_q[iss_ptr];
    assign issue_rob_line = iss_ptr;
    assign iss_store      = (kind_q[iss_ptr] == op_store);
    assign issue_valid    = used_q[iss_ptr] && !issued_q[iss_ptr] && src_ready1 && src_ready2
                            && (!iss_store || iss_ptr == cm_ptr) && !trap;
    assign issue_fire     = issue_valid && fu_ready;

    assign wb_preg = prd_q[wb_rob_line];

    // commit at the head once finished
    assign commit_valid = used_q[cm_ptr] && finished_q[cm_ptr];
    assign commit_pc    = pc_q[cm_ptr];
    assign commit_rd    = rd_q[cm_ptr];
    assign commit_prd   = prd_q[cm_ptr];
    assign free_preg    = old_q[cm_ptr];
    assign free_en      = commit_valid && (old_q[cm_ptr] != '0);
    assign commit_alloc = commit_valid && (prd_q[cm_ptr] != '0);

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            kind_q[tail_ptr] <= dispatch_kind;
            pc_q[tail_ptr]   <= dispatch_pc;
            rd_q[tail_ptr]   <= needs_preg ? dispatch_rd : '0;
            prs1_q[tail_ptr] <= src1_preg;
            prs2_q[tail_ptr] <= src2_preg;
            prd_q[tail_ptr]  <= needs_preg ? alloc_preg : '0;
            old_q[tail_ptr]  <= needs_preg ? old_preg : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            used_q     <= '0;
            issued_q   <= '0;
            finished_q <= '0;
            tail_ptr   <= '0;
            iss_ptr    <= '0;
            cm_ptr     <= '0;
        end else if (trap) begin
            // squash everything in flight, keep the tail where it is
            used_q     <= '0;
            issued_q   <= '0;
            finished_q <= '0;
            iss_ptr    <= tail_ptr;
            cm_ptr     <= tail_ptr;
        end else begin
            if (dispatch_fire) begin
                used_q[tail_ptr] <= 1'b1;
                tail_ptr         <= tail_ptr + 1'b1;
            end
            if (issue_fire) begin
                issued_q[iss_ptr] <= 1'b1;
                iss_ptr           <= iss_ptr + 1'b1;
            end
            if (wb_valid) begin
                finished_q[wb_rob_line] <= 1'b1;
            end
            if (commit_valid) begin
                used_q[cm_ptr]     <= 1'b0;
                issued_q[cm_ptr]   <= 1'b0;
                finished_q[cm_ptr] <= 1'b0;
                cm_ptr             <= cm_ptr + 1'b1;
            end
        end
    end

    a_wb_live: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> used_q[wb_rob_line] && issued_q[wb_rob_line]);
    a_commit_done: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> issued_q[cm_ptr]);

endmodule

// File: phys_regfile.sv
// physical register file
`timescale 1ns/1ps

module phys_regfile import rcu_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  preg_t                 rs1_preg,
    input  preg_t                 rs2_preg,
    input  logic                  wb_en,
    input  preg_t                 wb_preg,
    input  logic [data_width-1:0] wb_data,
    input  logic                  alloc_en,
    input  preg_t                 alloc_preg,
    output logic [data_width-1:0] rs1_data,
    output logic [data_width-1:0] rs2_data,
    output logic                  rs1_ready,
    output logic                  rs2_ready
);

    logic [data_width-1:0] data_q  [phys_regs];
    logic                  ready_q [phys_regs];
    logic                  wb_write;

    // instructions without a destination write back to P0, nothing is stored
    assign wb_write = wb_en && (wb_preg != '0);

    assign rs1_data  = (rs1_preg == '0) ? '0 : data_q[rs1_preg];
    assign rs2_data  = (rs2_preg == '0) ? '0 : data_q[rs2_preg];
    assign rs1_ready = (rs1_preg == '0) || ready_q[rs1_preg];
    assign rs2_ready = (rs2_preg == '0) || ready_q[rs2_preg];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < phys_regs; i++) begin
                ready_q[i] <= 1'b1;
            end
        end else begin
            if (alloc_en) begin
                ready_q[alloc_preg] <= 1'b0;
            end
            if (wb_write) begin
                ready_q[wb_preg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_write) begin
            data_q[wb_preg] <= wb_data;
        end
    end

    // a real write-back only lands on a register allocated and not yet written
    a_wb_pending: assert property (@(posedge clk) disable iff (reset)
        wb_write |-> !ready_q[wb_preg]);

endmodule

// File: rename_table.sv
// speculative and committed rename maps
`timescale 1ns/1ps

module rename_table import rcu_cfg_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  trap,
    input  logic  rename_en,
    input  areg_t rs1,
    input  areg_t rs2,
    input  areg_t rd,
    input  preg_t new_preg,
    input  logic  commit_en,
    input  areg_t commit_rd,
    input  preg_t commit_preg,
    output preg_t src1_preg,
    output preg_t src2_preg,
    output preg_t old_preg
);

    preg_t spec_map [arch_regs];
    preg_t cm_map   [arch_regs];

    // x0 is never renamed so it stays on P0
    assign src1_preg = spec_map[rs1];
    assign src2_preg = spec_map[rs2];
    assign old_preg  = spec_map[rd];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < arch_regs; i++) begin
                spec_map[i] <= '0;
                cm_map[i]   <= '0;
            end
        end else begin
            if (commit_en) begin
                cm_map[commit_rd] <= commit_preg;
            end
            if (trap) begin
                // restore, including a commit landing on this edge
                for (int i = 0; i < arch_regs; i++) begin
                    spec_map[i] <= (commit_en && commit_rd == areg_t'(i)) ? commit_preg
                                                                          : cm_map[i];
                end
            end else if (rename_en) begin
                spec_map[rd] <= new_preg;
            end
        end
    end

endmodule

// File: free_list.sv
// physical register free list
`timescale 1ns/1ps

module free_list import rcu_cfg_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  trap,
    input  logic  alloc,
    input  logic  free_en,
    input  preg_t free_preg,
    input  logic  commit_alloc,
    output preg_t alloc_preg,
    output logic  empty
);

    // one extra pointer bit tells full from empty
    preg_t               slots [phys_regs];
    logic [preg_width:0] rd_ptr;
    logic [preg_width:0] cm_rd_ptr;
    logic [preg_width:0] wr_ptr;
    logic [preg_width:0] count;
    logic                full;

    assign count      = wr_ptr - rd_ptr;
    assign empty      = (rd_ptr == wr_ptr);
    assign full       = (count == (preg_width + 1)'(phys_regs - 1));
    assign alloc_preg = slots[rd_ptr[preg_width-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            // P1..P31 in ascending order, P0 never enters the queue
            for (int i = 0; i < phys_regs - 1; i++) begin
                slots[i] <= preg_t'(i + 1);
            end
            rd_ptr    <= '0;
            cm_rd_ptr <= '0;
            wr_ptr    <= (preg_width + 1)'(phys_regs - 1);
        end else begin
            if (free_en) begin
                slots[wr_ptr[preg_width-1:0]] <= free_preg;
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (commit_alloc) begin
                cm_rd_ptr <= cm_rd_ptr + 1'b1;
            end
            // rewind to the commit point, counting a commit in the same cycle
            if (trap) begin
                rd_ptr <= commit_alloc ? cm_rd_ptr + 1'b1 : cm_rd_ptr;
            end else if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (reset) alloc |-> !empty);
    a_no_free_full: assert property (@(posedge clk) disable iff (reset) free_en |-> !full);

endmodule

// File: rcu_op_pkg.sv
// instruction kinds
package rcu_op_pkg;

    // kind carried through the reorder buffer
    // store issues only at the head
    typedef enum logic [1:0] {
        op_alu   = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } op_kind_t;

endpackage

// File: rcu_cfg_pkg.sv
// register control unit sizes
package rcu_cfg_pkg;

    // architectural and physical register files
    localparam int arch_regs  = 32;
    localparam int phys_regs  = 32;
    localparam int preg_width = 5;

    // reorder buffer
    localparam int rob_depth = 8;
    localparam int rob_width = 3;

    // datapath
    localparam int data_width = 64;
    localparam int pc_width   = 32;

    typedef logic [preg_width-1:0] preg_t;
    typedef logic [$clog2(arch_regs)-1:0] areg_t;
    typedef logic [rob_width-1:0] rob_line_t;

endpackage
